//--- axi_line_adapter.f
+incdir+include
hw/axi_line_adapter_pkg.sv
hw/line_req_dispatch.sv
hw/axi_write_engine.sv
hw/axi_read_engine.sv
hw/axi_line_adapter.sv
bench/axi_slave_model.sv
bench/tb_axi_line_adapter.sv

//--- bench/axi_slave_model.sv
// AXI slave memory model
`timescale 1ns/10ps
`include "axi_line_adapter_consts.svh"

module axi_slave_model
  import axi_line_adapter_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  axi_req_t  axi_req_i,
  output axi_resp_t axi_resp_o
);

  localparam int unsigned MEM_WORDS = 64;
  localparam logic [31:0] LCG_SEED  = 32'h7d36aa85;

  // word index is address bits 8:3
  logic [`XLEN-1:0]       mem [MEM_WORDS];
  logic [31:0]            rnd_q;
  axi_aw_t                aw_q;
  logic                   aw_got_q;
  logic [`XLEN-1:0]       wdata_q [`LINE_BEATS];
  logic [`XLEN/8-1:0]     wstrb_q [`LINE_BEATS];
  logic [`BEAT_IDX_W-1:0] w_cnt_q;
  logic                   w_done_q;
  axi_b_t                 b_q;
  logic                   b_valid_q;
  axi_ar_t                ar_q;
  logic                   ar_got_q;
  logic [7:0]             r_beat_q;
  logic                   r_valid_q;
  logic                   resv_valid_q;
  logic [`XLEN-1:0]       resv_addr_q;
  logic                   sc_hit;
  logic                   commit_wr;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   ar_fire;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [`XLEN-1:0] merge_bytes(input logic [`XLEN-1:0] old_w,
                                                   input logic [`XLEN-1:0] new_w,
                                                   input logic [`XLEN/8-1:0] be);
    logic [`XLEN-1:0] res;
    res = old_w;
    for (int b = 0; b < `XLEN/8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // -------------------------------------------------------------------------
  // channel outputs, readies stall at random
  // -------------------------------------------------------------------------
  always_comb begin
    axi_resp_o          = '0;
    axi_resp_o.aw_ready = !aw_got_q && (rnd_q[31:30] != 2'b00);
    axi_resp_o.w_ready  = !w_done_q && (rnd_q[29:28] != 2'b00);
    axi_resp_o.ar_ready = !ar_got_q && (rnd_q[27:26] != 2'b00);
    axi_resp_o.b        = b_q;
    axi_resp_o.b_valid  = b_valid_q;
    axi_resp_o.r.data   = mem[ar_q.addr[8:3] + 6'(r_beat_q)];
    axi_resp_o.r.id     = ar_q.id;
    axi_resp_o.r.resp   = ar_q.lock ? `AXI_RESP_EXOKAY : `AXI_RESP_OKAY;
    axi_resp_o.r.last   = (r_beat_q == ar_q.len);
    axi_resp_o.r_valid  = r_valid_q;
  end

  assign aw_fire = axi_req_i.aw_valid && axi_resp_o.aw_ready;
  assign w_fire  = axi_req_i.w_valid && axi_resp_o.w_ready;
  assign ar_fire = axi_req_i.ar_valid && axi_resp_o.ar_ready;

  // exclusive write only lands on a live reservation
  assign sc_hit    = aw_q.lock && resv_valid_q && (resv_addr_q == aw_q.addr);
  assign commit_wr = aw_got_q && w_done_q && !b_valid_q && rnd_q[25];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_q        <= LCG_SEED;
      aw_q         <= '0;
      aw_got_q     <= 1'b0;
      w_cnt_q      <= '0;
      w_done_q     <= 1'b0;
      b_q          <= '0;
      b_valid_q    <= 1'b0;
      ar_q         <= '0;
      ar_got_q     <= 1'b0;
      r_beat_q     <= '0;
      r_valid_q    <= 1'b0;
      resv_valid_q <= 1'b0;
      resv_addr_q  <= '0;
    end else begin
      rnd_q <= lcg_next(rnd_q);
      if (aw_fire) begin
        aw_q     <= axi_req_i.aw;
        aw_got_q <= 1'b1;
      end
      if (w_fire) begin
        w_cnt_q <= w_cnt_q + 1'b1;
        if (axi_req_i.w.last) begin
          w_done_q <= 1'b1;
        end
      end
      // address and all data in, answer on B
      if (commit_wr) begin
        b_q.id    <= aw_q.id;
        b_q.resp  <= sc_hit ? `AXI_RESP_EXOKAY : `AXI_RESP_OKAY;
        b_valid_q <= 1'b1;
        aw_got_q  <= 1'b0;
        w_done_q  <= 1'b0;
        w_cnt_q   <= '0;
        if (resv_valid_q && resv_addr_q == aw_q.addr) begin
          resv_valid_q <= 1'b0;
        end
      end
      if (b_valid_q && axi_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (ar_fire) begin
        ar_q     <= axi_req_i.ar;
        ar_got_q <= 1'b1;
        r_beat_q <= '0;
        if (axi_req_i.ar.lock) begin
          resv_valid_q <= 1'b1;
          resv_addr_q  <= axi_req_i.ar.addr;
        end
      end
      if (ar_got_q && !r_valid_q && rnd_q[24]) begin
        r_valid_q <= 1'b1;
      end
      if (r_valid_q && axi_req_i.r_ready) begin
        r_valid_q <= 1'b0;
        r_beat_q  <= r_beat_q + 8'd1;
        if (axi_resp_o.r.last) begin
          ar_got_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_fire) begin
      wdata_q[w_cnt_q] <= axi_req_i.w.data;
      wstrb_q[w_cnt_q] <= axi_req_i.w.strb;
    end
  end

  // backing store, filled from the word index at reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= {32'hfeed_0000 + 32'(i), 32'(i) * 32'h0101_0101 ^ 32'h5a5a_0000};
      end
    end else if (commit_wr && (!aw_q.lock || sc_hit)) begin
      for (int i = 0; i < `LINE_BEATS; i++) begin
        if (8'(i) <= aw_q.len) begin
          mem[aw_q.addr[8:3] + 6'(i)] <= merge_bytes(mem[aw_q.addr[8:3] + 6'(i)],
                                                     wdata_q[i], wstrb_q[i]);
        end
      end
    end
  end

endmodule

//--- bench/tb_axi_line_adapter.sv
// Line adapter testbench
`timescale 1ns/10ps
`include "axi_line_adapter_consts.svh"

module tb_axi_line_adapter
  import axi_line_adapter_pkg::*;
();

  // about 30 transactions at up to 125 cycles each
  localparam int unsigned TXN_COUNT      = 32;
  localparam int unsigned CYCLES_PER_TXN = 125;
  localparam int unsigned MAX_CYCLES     = TXN_COUNT * CYCLES_PER_TXN;

  logic             clk_i;
  logic             rst_ni;
  logic             req;
  cache_req_t       req_data;
  logic             gnt_o;
  logic             valid_o;
  cache_rsp_t       rsp_o;
  logic [`XLEN-1:0] cw;
  logic             cw_valid;
  axi_req_t         axi_req;
  axi_resp_t        axi_resp;

  // expected memory contents indexed by address bits 8:3
  logic [`XLEN-1:0] shadow [64];
  string            test_name = "reset";
  logic             cur_we = 1'b0;
  req_kind_e        cur_kind = REQ_SINGLE;
  logic [7:0]       exp_len = 8'd0;
  logic [2:0]       exp_size = 3'd0;
  logic [`XLEN-1:0] exp_cw = '0;
  logic             pending = 1'b0;
  logic [7:0]       w_beats = 8'd0;
  int unsigned      cw_count = 0;
  int unsigned      cycle_count = 0;

  axi_line_adapter dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req),
    .req_data_i            (req_data),
    .gnt_o                 (gnt_o),
    .valid_o               (valid_o),
    .rsp_o                 (rsp_o),
    .critical_word_o       (cw),
    .critical_word_valid_o (cw_valid),
    .axi_req_o             (axi_req),
    .axi_resp_i            (axi_resp)
  );

  axi_slave_model u_slave (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .axi_req_i  (axi_req),
    .axi_resp_o (axi_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
    stop_on_error($sformatf("MISMATCH %s expected %h actual %h", test_name, exp, act));
  endtask

  task automatic check_word(input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
    assert (act === exp) else report_mismatch(exp, act);
  endtask

  function automatic logic [`XLEN-1:0] merge_bytes(input logic [`XLEN-1:0] old_w,
                                                   input logic [`XLEN-1:0] new_w,
                                                   input logic [`XLEN/8-1:0] be);
    logic [`XLEN-1:0] res;
    res = old_w;
    for (int b = 0; b < `XLEN/8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // -------------------------------------------------------------------------
  // protocol monitor
  // -------------------------------------------------------------------------
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      stop_on_error($sformatf("simulation timed out after %0d cycles", cycle_count));
    end
    if (rst_ni) begin
      if (gnt_o) begin
        assert (req) else stop_on_error("gnt_o asserted without a request");
      end
      // a second valid_o for one request finds nothing outstanding
      if (valid_o) begin
        assert (pending) else stop_on_error("valid_o without an outstanding grant");
      end
      if (cw_valid) begin
        assert (pending && !cur_we && cur_kind == REQ_LINE)
          else stop_on_error("critical word pulse outside a line read");
        assert (cw === exp_cw) else report_mismatch(exp_cw, cw);
      end
      if (valid_o && !cur_we && cur_kind == REQ_LINE) begin
        assert (cw_count == 1) else stop_on_error("critical word not seen exactly once");
      end
      if (axi_req.aw_valid && axi_resp.aw_ready) begin
        assert (axi_req.aw.len == exp_len)
          else report_mismatch(64'(exp_len), 64'(axi_req.aw.len));
        assert (axi_req.aw.size == exp_size)
          else report_mismatch(64'(exp_size), 64'(axi_req.aw.size));
        assert (axi_req.aw.burst == `AXI_BURST_INCR)
          else report_mismatch(64'(`AXI_BURST_INCR), 64'(axi_req.aw.burst));
      end
      if (axi_req.ar_valid && axi_resp.ar_ready) begin
        assert (axi_req.ar.len == exp_len)
          else report_mismatch(64'(exp_len), 64'(axi_req.ar.len));
        assert (axi_req.ar.size == exp_size)
          else report_mismatch(64'(exp_size), 64'(axi_req.ar.size));
        assert (axi_req.ar.burst == `AXI_BURST_INCR)
          else report_mismatch(64'(`AXI_BURST_INCR), 64'(axi_req.ar.burst));
      end
      if (axi_req.w_valid && axi_resp.w_ready) begin
        assert (axi_req.w.last == (w_beats == exp_len))
          else report_mismatch(64'(w_beats == exp_len), 64'(axi_req.w.last));
        w_beats <= w_beats + 8'd1;
      end
      if (cw_valid) begin
        cw_count <= cw_count + 1;
      end
      if (gnt_o) begin
        pending <= 1'b1;
        w_beats <= 8'd0;
      end
      if (valid_o) begin
        pending  <= 1'b0;
        cw_count <= 0;
      end
    end
  end

  // issue one request, hold it until gnt_o and wait for valid_o
  task automatic run_txn(input logic we, input req_kind_e kind, input amo_e amo,
                         input logic [1:0] size, input logic [`XLEN-1:0] addr,
                         input line_t wdata, input strb_line_t be,
                         input logic [`ID_WIDTH-1:0] id, output cache_rsp_t rsp);
    cache_req_t r;
    r       = '0;
    r.addr  = addr;
    r.we    = we;
    r.kind  = kind;
    r.amo   = amo;
    r.size  = size;
    r.id    = id;
    r.wdata = wdata;
    r.be    = be;
    @(posedge clk_i);
    cur_we   = we;
    cur_kind = kind;
    exp_len  = (kind == REQ_LINE) ? 8'd3 : 8'd0;
    // line beats are full 8-byte words
    exp_size = (kind == REQ_LINE) ? 3'd3 : {1'b0, size};
    exp_cw   = shadow[addr[8:3]];
    req      <= 1'b1;
    req_data <= r;
    do begin
      @(posedge clk_i);
    end while (!gnt_o);
    req <= 1'b0;
    while (!valid_o) begin
      @(posedge clk_i);
    end
    rsp = rsp_o;
    assert (rsp_o.id === id) else report_mismatch(64'(id), 64'(rsp_o.id));
  endtask

  task automatic write_word(input string name, input logic [`XLEN-1:0] addr,
                            input logic [1:0] size, input logic [`XLEN-1:0] data,
                            input logic [7:0] be, input logic [`ID_WIDTH-1:0] id);
    line_t      wd;
    strb_line_t st;
    cache_rsp_t rsp;
    test_name = name;
    wd        = '0;
    st        = '0;
    wd[0]     = data;
    st[0]     = be;
    run_txn(1'b1, REQ_SINGLE, AMO_NONE, size, addr, wd, st, id, rsp);
    shadow[addr[8:3]] = merge_bytes(shadow[addr[8:3]], data, be);
  endtask

  task automatic write_line(input string name, input logic [`XLEN-1:0] addr,
                            input logic [31:0] tag, input logic [`ID_WIDTH-1:0] id);
    line_t      wd;
    cache_rsp_t rsp;
    test_name = name;
    for (int i = 0; i < `LINE_BEATS; i++) begin
      wd[i] = {tag, 32'(i) * 32'h9e37_79b9};
    end
    run_txn(1'b1, REQ_LINE, AMO_NONE, 2'd3, addr, wd, '1, id, rsp);
    for (int i = 0; i < `LINE_BEATS; i++) begin
      shadow[{addr[8:5], 2'(i)}] = wd[i];
    end
  endtask

  task automatic read_check(input string name, input req_kind_e kind, input amo_e amo,
                            input logic [`XLEN-1:0] addr, input logic [1:0] size,
                            input logic [`ID_WIDTH-1:0] id);
    cache_rsp_t rsp;
    test_name = name;
    run_txn(1'b0, kind, amo, size, addr, '0, '0, id, rsp);
    if (kind == REQ_LINE) begin
      for (int i = 0; i < `LINE_BEATS; i++) begin
        check_word(shadow[{addr[8:5], 2'(i)}], rsp.rdata[i]);
      end
    end else begin
      check_word(shadow[addr[8:3]], rsp.rdata[0]);
    end
  endtask

  task automatic store_cond(input string name, input logic [`XLEN-1:0] addr,
                            input logic [1:0] size, input logic [`XLEN-1:0] data,
                            input logic [7:0] be, input logic [`ID_WIDTH-1:0] id,
                            input logic expect_ok);
    line_t            wd;
    strb_line_t       st;
    cache_rsp_t       rsp;
    logic [`XLEN-1:0] exp;
    test_name = name;
    wd        = '0;
    st        = '0;
    wd[0]     = data;
    st[0]     = be;
    run_txn(1'b1, REQ_SINGLE, AMO_SC, size, addr, wd, st, id, rsp);
    // zero on success and a one per 32-bit half for a failed word SC
    if (expect_ok) begin
      exp               = '0;
      shadow[addr[8:3]] = merge_bytes(shadow[addr[8:3]], data, be);
    end else if (size == 2'd2) begin
      exp = 64'h0000_0001_0000_0001;
    end else begin
      exp = 64'h0000_0000_0000_0001;
    end
    check_word(exp, rsp.rdata[0]);
  endtask

  // -------------------------------------------------------------------------
  // stimulus
  // -------------------------------------------------------------------------
  initial begin
    rst_ni   = 1'b0;
    req      = 1'b0;
    req_data = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    assert (!gnt_o && !valid_o && !cw_valid && !axi_req.aw_valid && !axi_req.w_valid &&
            !axi_req.ar_valid && !axi_req.b_ready && !axi_req.r_ready)
      else stop_on_error("outputs not low after reset");

    // every size followed by a merged read-back
    write_word("single_rw", 64'h040, 2'd3, 64'h0123_4567_89ab_cdef, 8'hff, 4'd3);
    write_word("single_rw", 64'h044, 2'd2, 64'hcafe_f00d_0000_0000, 8'hf0, 4'd5);
    write_word("single_rw", 64'h040, 2'd1, 64'h0000_0000_0000_beef, 8'h03, 4'd6);
    write_word("single_rw", 64'h042, 2'd0, 64'h0000_0000_005a_0000, 8'h04, 4'd7);
    read_check("single_rw", REQ_SINGLE, AMO_NONE, 64'h040, 2'd3, 4'd9);
    read_check("single_rw", REQ_SINGLE, AMO_NONE, 64'h044, 2'd2, 4'd10);

    // line bursts with the critical word at each offset
    write_line("line_rw", 64'h080, 32'h1ead_0001, 4'd1);
    write_line("line_rw", 64'h0c0, 32'h1ead_0002, 4'd2);
    read_check("critical_word", REQ_LINE, AMO_NONE, 64'h080, 2'd3, 4'd11);
    read_check("critical_word", REQ_LINE, AMO_NONE, 64'h088, 2'd3, 4'd12);
    read_check("critical_word", REQ_LINE, AMO_NONE, 64'h0d0, 2'd3, 4'd13);
    read_check("critical_word", REQ_LINE, AMO_NONE, 64'h0d8, 2'd3, 4'd14);

    write_word("sc_success", 64'h100, 2'd3, 64'h1111_2222_3333_4444, 8'hff, 4'd1);
    write_word("sc_success", 64'h108, 2'd3, 64'h5555_6666_7777_8888, 8'hff, 4'd2);
    read_check("sc_success", REQ_SINGLE, AMO_LR, 64'h100, 2'd3, 4'd3);
    store_cond("sc_success", 64'h100, 2'd3, 64'h9999_aaaa_bbbb_cccc, 8'hff, 4'd4, 1'b1);
    read_check("sc_success", REQ_SINGLE, AMO_NONE, 64'h100, 2'd3, 4'd5);
    read_check("sc_success", REQ_SINGLE, AMO_LR, 64'h10c, 2'd2, 4'd6);
    store_cond("sc_success", 64'h10c, 2'd2, 64'hdead_beef_0000_0000, 8'hf0, 4'd7, 1'b1);
    read_check("sc_success", REQ_SINGLE, AMO_NONE, 64'h108, 2'd3, 4'd8);

    // no reservation or one on another address
    write_word("sc_fail", 64'h140, 2'd3, 64'h0a0a_0b0b_0c0c_0d0d, 8'hff, 4'd1);
    write_word("sc_fail", 64'h148, 2'd3, 64'h1234_5678_9abc_def0, 8'hff, 4'd2);
    write_word("sc_fail", 64'h188, 2'd3, 64'h0f0f_1e1e_2d2d_3c3c, 8'hff, 4'd3);
    store_cond("sc_fail", 64'h140, 2'd3, 64'hffff_ffff_ffff_ffff, 8'hff, 4'd4, 1'b0);
    read_check("sc_fail", REQ_SINGLE, AMO_NONE, 64'h140, 2'd3, 4'd5);
    store_cond("sc_fail", 64'h14c, 2'd2, 64'h7777_7777_0000_0000, 8'hf0, 4'd6, 1'b0);
    read_check("sc_fail", REQ_SINGLE, AMO_NONE, 64'h148, 2'd3, 4'd7);
    read_check("sc_fail", REQ_SINGLE, AMO_LR, 64'h148, 2'd3, 4'd8);
    store_cond("sc_fail", 64'h188, 2'd3, 64'h6666_5555_4444_3333, 8'hff, 4'd9, 1'b0);
    read_check("sc_fail", REQ_SINGLE, AMO_NONE, 64'h188, 2'd3, 4'd10);

    $display("Verification passed");
    $finish;
  end

endmodule

//--- hw/axi_line_adapter.sv
// AXI cache line adapter
`timescale 1ns/10ps
`include "axi_line_adapter_consts.svh"

module axi_line_adapter
  import axi_line_adapter_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  cache_req_t       req_data_i,
  output logic             gnt_o,
  output logic             valid_o,
  output cache_rsp_t       rsp_o,
  output logic [`XLEN-1:0] critical_word_o,
  output logic             critical_word_valid_o,
  output axi_req_t         axi_req_o,
  input  axi_resp_t        axi_resp_i
);

  logic       wr_start;
  logic       rd_start;
  logic       wr_gnt;
  logic       rd_gnt;
  logic       wr_done;
  logic       rd_done;
  cache_rsp_t wr_rsp;
  cache_rsp_t rd_rsp;

  line_req_dispatch u_dispatch (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .we_i       (req_data_i.we),
    .gnt_o      (gnt_o),
    .valid_o    (valid_o),
    .rsp_o      (rsp_o),
    .wr_start_o (wr_start),
    .rd_start_o (rd_start),
    .wr_gnt_i   (wr_gnt),
    .rd_gnt_i   (rd_gnt),
    .wr_done_i  (wr_done),
    .rd_done_i  (rd_done),
    .wr_rsp_i   (wr_rsp),
    .rd_rsp_i   (rd_rsp)
  );

  // write engine owns aw, w and b_ready
  axi_write_engine u_wr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (wr_start),
    .req_i      (req_data_i),
    .aw_o       (axi_req_o.aw),
    .aw_valid_o (axi_req_o.aw_valid),
    .w_o        (axi_req_o.w),
    .w_valid_o  (axi_req_o.w_valid),
    .b_ready_o  (axi_req_o.b_ready),
    .aw_ready_i (axi_resp_i.aw_ready),
    .w_ready_i  (axi_resp_i.w_ready),
    .b_i        (axi_resp_i.b),
    .b_valid_i  (axi_resp_i.b_valid),
    .gnt_o      (wr_gnt),
    .done_o     (wr_done),
    .rsp_o      (wr_rsp)
  );

  // read engine owns ar and r_ready
  axi_read_engine u_rd (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .start_i               (rd_start),
    .req_i                 (req_data_i),
    .ar_o                  (axi_req_o.ar),
    .ar_valid_o            (axi_req_o.ar_valid),
    .r_ready_o             (axi_req_o.r_ready),
    .ar_ready_i            (axi_resp_i.ar_ready),
    .r_i                   (axi_resp_i.r),
    .r_valid_i             (axi_resp_i.r_valid),
    .gnt_o                 (rd_gnt),
    .done_o                (rd_done),
    .rsp_o                 (rd_rsp),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o)
  );

endmodule

//--- hw/axi_line_adapter_pkg.sv
// Line adapter types
`include "axi_line_adapter_consts.svh"

package axi_line_adapter_pkg;

  // atomic kind of a cache request
  typedef enum logic [1:0] {
    AMO_NONE = 2'd0,
    AMO_LR   = 2'd1,
    AMO_SC   = 2'd2
  } amo_e;

  typedef enum logic {
    REQ_SINGLE = 1'b0,
    REQ_LINE   = 1'b1
  } req_kind_e;

  typedef logic [`LINE_BEATS-1:0][`XLEN-1:0]   line_t;
  typedef logic [`LINE_BEATS-1:0][`XLEN/8-1:0] strb_line_t;

  // request from the cache side
  typedef struct packed {
    logic [`XLEN-1:0]     addr;
    logic                 we;
    req_kind_e            kind;
    amo_e                 amo;
    logic [1:0]           size;
    logic [`ID_WIDTH-1:0] id;
    line_t                wdata;
    strb_line_t           be;
  } cache_req_t;

  // ---------------------------------------------------------------------
  // AXI channels
  // ---------------------------------------------------------------------

  typedef struct packed {
    logic [`XLEN-1:0]     addr;
    logic [`ID_WIDTH-1:0] id;
    logic [7:0]           len;
    logic [2:0]           size;
    logic [1:0]           burst;
    logic                 lock;
  } axi_aw_t;

  // read address carries the same fields
  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    logic [`XLEN-1:0]   data;
    logic [`XLEN/8-1:0] strb;
    logic               last;
  } axi_w_t;

  typedef struct packed {
    logic [`XLEN-1:0]     data;
    logic [`ID_WIDTH-1:0] id;
    logic [1:0]           resp;
    logic                 last;
  } axi_r_t;

  typedef struct packed {
    logic [`ID_WIDTH-1:0] id;
    logic [1:0]           resp;
  } axi_b_t;

  typedef struct packed {
    axi_aw_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    axi_ar_t ar;
    logic    ar_valid;
    logic    b_ready;
    logic    r_ready;
  } axi_req_t;

  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    logic   ar_ready;
    axi_b_t b;
    logic   b_valid;
    axi_r_t r;
    logic   r_valid;
  } axi_resp_t;

  // payload that goes with valid_o
  typedef struct packed {
    line_t                rdata;
    logic [`ID_WIDTH-1:0] id;
  } cache_rsp_t;

endpackage

//--- hw/axi_read_engine.sv
// AXI read engine
`timescale 1ns/10ps
`include "axi_line_adapter_consts.svh"

module axi_read_engine
  import axi_line_adapter_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,
  input  cache_req_t       req_i,
  output axi_ar_t          ar_o,
  output logic             ar_valid_o,
  output logic             r_ready_o,
  input  logic             ar_ready_i,
  input  axi_r_t           r_i,
  input  logic             r_valid_i,
  output logic             gnt_o,
  output logic             done_o,
  output cache_rsp_t       rsp_o,
  output logic [`XLEN-1:0] critical_word_o,
  output logic             critical_word_valid_o
);

  typedef enum logic [1:0] {
    R_IDLE,
    R_ADDR,
    R_DATA,
    R_DONE
  } rd_state_e;

  rd_state_e              state_q;
  logic [`BEAT_IDX_W-1:0] beat_q;
  logic [`BEAT_IDX_W-1:0] offset_q;
  logic                   line_mode_q;
  line_t                  line_q;
  logic [`ID_WIDTH-1:0]   id_q;
  logic                   is_line;
  logic [`XLEN-1:0]       line_addr;
  logic [`BEAT_IDX_W-1:0] line_idx;
  logic                   r_fire;

  assign is_line   = (req_i.kind == REQ_LINE);
  assign line_addr = {req_i.addr[`XLEN-1:`LINE_OFFSET], {`LINE_OFFSET{1'b0}}};

  // line reads always start at the line base
  always_comb begin
    ar_o.addr  = is_line ? line_addr : req_i.addr;
    ar_o.id    = req_i.id;
    ar_o.len   = is_line ? 8'(`LINE_BEATS - 1) : 8'd0;
    ar_o.size  = is_line ? `AXI_SIZE_WORD : {1'b0, req_i.size};
    ar_o.burst = `AXI_BURST_INCR;
    // load-reserved goes out as an exclusive read
    ar_o.lock  = (req_i.amo == AMO_LR);
  end

  assign ar_valid_o = (state_q == R_ADDR);
  assign gnt_o      = ar_valid_o && ar_ready_i;
  assign r_ready_o  = (state_q == R_DATA);
  assign r_fire     = r_ready_o && r_valid_i;

  // single reads land in word 0
  assign line_idx = line_mode_q ? beat_q : '0;

  assign critical_word_o       = r_i.data;
  assign critical_word_valid_o = r_fire && line_mode_q && (beat_q == offset_q);

  assign done_o      = (state_q == R_DONE);
  assign rsp_o.rdata = line_q;
  assign rsp_o.id    = id_q;

  // -------------------------------------------------------------------------
  // control
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= R_IDLE;
      beat_q      <= '0;
      offset_q    <= '0;
      line_mode_q <= 1'b0;
    end else begin
      case (state_q)
        R_IDLE: begin
          if (start_i) begin
            state_q <= R_ADDR;
          end
        end
        R_ADDR: begin
          if (gnt_o) begin
            state_q     <= R_DATA;
            beat_q      <= '0;
            offset_q    <= req_i.addr[`LINE_OFFSET-1:`LINE_OFFSET-`BEAT_IDX_W];
            line_mode_q <= is_line;
          end
        end
        R_DATA: begin
          if (r_fire) begin
            beat_q <= beat_q + 1'b1;
            if (r_i.last) begin
              state_q <= R_DONE;
            end
          end
        end
        // one cycle for the assembled line to settle
        R_DONE: begin
          state_q <= R_IDLE;
        end
        default: begin
          state_q <= R_IDLE;
        end
      endcase
    end
  end

  // line assembly
  always_ff @(posedge clk_i) begin
    if (r_fire) begin
      line_q[line_idx] <= r_i.data;
      if (r_i.last) begin
        id_q <= r_i.id;
      end
    end
  end

endmodule

//--- hw/axi_write_engine.sv
// AXI write engine
`timescale 1ns/10ps
`include "axi_line_adapter_consts.svh"

module axi_write_engine
  import axi_line_adapter_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  cache_req_t req_i,
  output axi_aw_t    aw_o,
  output logic       aw_valid_o,
  output axi_w_t     w_o,
  output logic       w_valid_o,
  output logic       b_ready_o,
  input  logic       aw_ready_i,
  input  logic       w_ready_i,
  input  axi_b_t     b_i,
  input  logic       b_valid_i,
  output logic       gnt_o,
  output logic       done_o,
  output cache_rsp_t rsp_o
);

  localparam logic [`BEAT_IDX_W-1:0] LAST_BEAT = `BEAT_IDX_W'(`LINE_BEATS - 1);
  // SC failure words, a 32-bit SC sees a one in both halves
  localparam logic [`XLEN-1:0] SC_FAIL_D = {{(`XLEN-1){1'b0}}, 1'b1};
  localparam logic [`XLEN-1:0] SC_FAIL_W = {2{{(`XLEN/2-1){1'b0}}, 1'b1}};

  typedef enum logic [1:0] {
    W_IDLE,
    W_SEND,
    W_RESP
  } wr_state_e;

  wr_state_e              state_q;
  logic                   aw_pend_q;
  logic                   w_pend_q;
  logic [`BEAT_IDX_W-1:0] beats_left_q;
  amo_e                   amo_q;
  logic [1:0]             size_q;
  logic                   is_line;
  logic [`BEAT_IDX_W-1:0] beat_idx;
  logic [`XLEN-1:0]       line_addr;
  logic                   aw_fire;
  logic                   w_fire;

  assign is_line   = (req_i.kind == REQ_LINE);
  assign line_addr = {req_i.addr[`XLEN-1:`LINE_OFFSET], {`LINE_OFFSET{1'b0}}};
  // beats count down, so the word index counts up
  assign beat_idx  = is_line ? LAST_BEAT - beats_left_q : '0;

  // -------------------------------------------------------------------------
  // address and data channels
  // -------------------------------------------------------------------------
  always_comb begin
    aw_o.addr  = is_line ? line_addr : req_i.addr;
    aw_o.id    = req_i.id;
    aw_o.len   = is_line ? 8'(`LINE_BEATS - 1) : 8'd0;
    aw_o.size  = is_line ? `AXI_SIZE_WORD : {1'b0, req_i.size};
    aw_o.burst = `AXI_BURST_INCR;
    // store-conditional goes out as an exclusive write
    aw_o.lock  = (req_i.amo == AMO_SC);
    w_o.data   = req_i.wdata[beat_idx];
    w_o.strb   = req_i.be[beat_idx];
    w_o.last   = (beats_left_q == '0);
  end

  assign aw_valid_o = (state_q == W_SEND) && aw_pend_q;
  assign w_valid_o  = (state_q == W_SEND) && w_pend_q;
  assign aw_fire    = aw_valid_o && aw_ready_i;
  assign w_fire     = w_valid_o && w_ready_i;

  // granted once both AW and the last W are through, in either order
  assign gnt_o = (state_q == W_SEND) && (!aw_pend_q || aw_fire) &&
                 (!w_pend_q || (w_fire && w_o.last));

  assign b_ready_o = (state_q == W_RESP);
  assign done_o    = b_ready_o && b_valid_i;

  // SC result word, zero on success
  always_comb begin
    rsp_o.id    = b_i.id;
    rsp_o.rdata = '0;
    if (amo_q == AMO_SC && b_i.resp != `AXI_RESP_EXOKAY) begin
      rsp_o.rdata[0] = (size_q == 2'b10) ? SC_FAIL_W : SC_FAIL_D;
    end
  end

  // -------------------------------------------------------------------------
  // control
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= W_IDLE;
      aw_pend_q    <= 1'b0;
      w_pend_q     <= 1'b0;
      beats_left_q <= '0;
    end else begin
      case (state_q)
        W_IDLE: begin
          if (start_i) begin
            state_q      <= W_SEND;
            aw_pend_q    <= 1'b1;
            w_pend_q     <= 1'b1;
            beats_left_q <= is_line ? LAST_BEAT : '0;
          end
        end
        W_SEND: begin
          if (aw_fire) begin
            aw_pend_q <= 1'b0;
          end
          if (w_fire) begin
            if (w_o.last) begin
              w_pend_q <= 1'b0;
            end else begin
              beats_left_q <= beats_left_q - 1'b1;
            end
          end
          if (gnt_o) begin
            state_q <= W_RESP;
          end
        end
        W_RESP: begin
          if (b_valid_i) begin
            state_q <= W_IDLE;
          end
        end
        default: begin
          state_q <= W_IDLE;
        end
      endcase
    end
  end

  // kept for the B phase, the request may change after the grant
  always_ff @(posedge clk_i) begin
    if (state_q == W_IDLE && start_i) begin
      amo_q  <= req_i.amo;
      size_q <= req_i.size;
    end
  end

endmodule

//--- hw/line_req_dispatch.sv
// Request dispatcher
`timescale 1ns/10ps

module line_req_dispatch
  import axi_line_adapter_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       we_i,
  output logic       gnt_o,
  output logic       valid_o,
  output cache_rsp_t rsp_o,
  output logic       wr_start_o,
  output logic       rd_start_o,
  input  logic       wr_gnt_i,
  input  logic       rd_gnt_i,
  input  logic       wr_done_i,
  input  logic       rd_done_i,
  input  cache_rsp_t wr_rsp_i,
  input  cache_rsp_t rd_rsp_i
);

  typedef enum logic [1:0] {
    D_IDLE,
    D_WR_BUSY,
    D_RD_BUSY
  } disp_state_e;

  disp_state_e state_q;
  disp_state_e state_d;

  // a request starts exactly one engine, and only from idle
  assign wr_start_o = (state_q == D_IDLE) && req_i && we_i;
  assign rd_start_o = (state_q == D_IDLE) && req_i && !we_i;

  // -------------------------------------------------------------------------
  // routing of grant and response
  // -------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    gnt_o   = 1'b0;
    valid_o = 1'b0;
    rsp_o   = wr_rsp_i;

    case (state_q)
      D_IDLE: begin
        if (wr_start_o) begin
          state_d = D_WR_BUSY;
        end else if (rd_start_o) begin
          state_d = D_RD_BUSY;
        end
      end
      D_WR_BUSY: begin
        gnt_o   = wr_gnt_i;
        valid_o = wr_done_i;
        if (wr_done_i) begin
          state_d = D_IDLE;
        end
      end
      D_RD_BUSY: begin
        gnt_o   = rd_gnt_i;
        valid_o = rd_done_i;
        rsp_o   = rd_rsp_i;
        if (rd_done_i) begin
          state_d = D_IDLE;
        end
      end
      default: begin
        state_d = D_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= D_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- include/axi_line_adapter_consts.svh
// Line adapter constants
`ifndef AXI_LINE_ADAPTER_CONSTS_SVH
`define AXI_LINE_ADAPTER_CONSTS_SVH

// -------------------------------------------------------------------------
// data path geometry
// -------------------------------------------------------------------------

// bus word and address width
`define XLEN 64
// one cache line
`define LINE_WIDTH 256
// bus words per line
`define LINE_BEATS 4
// selects a word inside a line
`define BEAT_IDX_W 2
// byte offset bits of a line address
`define LINE_OFFSET 5
`define ID_WIDTH 4

// -------------------------------------------------------------------------
// AXI encodings
// -------------------------------------------------------------------------

`define AXI_BURST_INCR 2'b01
// full bus width beat, 8 bytes
`define AXI_SIZE_WORD 3'd3
`define AXI_RESP_OKAY 2'b00
// exclusive access succeeded
`define AXI_RESP_EXOKAY 2'b01

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the line adapter testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_axi_line_adapter -f axi_line_adapter.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_axi_line_adapter > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification passed" "$LOG"; then
  exit 0
fi
exit 1
